// ==== include/ldpc_hs_consts.svh ====
/*
  LDPC Hs cycle context reader constants
  field widths of the packed table words, table depth
  and the default read pipeline depth
*/

`ifndef LDPC_HS_CONSTS_SVH
`define LDPC_HS_CONSTS_SVH

// ----------------------------------------
// field widths
// ----------------------------------------

// column index of the base matrix
`define LDPC_HS_COL_W     8
// cycle index, also the packed node address
`define LDPC_HS_CYCLE_W   8
// circulant shift
`define LDPC_HS_SHIFT_W   9

// ----------------------------------------
// depths
// ----------------------------------------

// extra word/strobe delay between rom and address generator
`define LDPC_HS_PIPE      1
// every table is padded up to this many words
`define LDPC_HS_MAX_DEPTH 8

`endif

// ==== include/ldpc_hs_tables.svh ====
/*
  LDPC Hs packed cycle context tables
  each word holds a vertical step entry (column ordered) and a
  horizontal step entry (row ordered), padded to the max depth
  word layout is vcol_idx, veop, vpacked_addr, mask_0_bit, eop, col_idx, shift
*/

`ifndef LDPC_HS_TABLES_SVH
`define LDPC_HS_TABLES_SVH

// short 11/45, two rows of three columns
localparam cycle_idx_t short_11by45_size = 8'd6;
localparam cycle_ctx_t short_11by45_tab [`LDPC_HS_MAX_DEPTH] = '{
  '{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd17},
  '{8'd1, 1'b1, 8'd3, 1'b0, 1'b0, 8'd2, 9'd101},
  '{8'd2, 1'b1, 8'd1, 1'b0, 1'b1, 8'd5, 9'd250},
  '{8'd3, 1'b1, 8'd4, 1'b1, 1'b0, 8'd1, 9'd33},
  '{8'd5, 1'b0, 8'd2, 1'b0, 1'b0, 8'd3, 9'd7},
  '{8'd5, 1'b1, 8'd5, 1'b0, 1'b1, 8'd5, 9'd310},
  '0,
  '0
};

// short 4/15, rows of three and four columns
localparam cycle_idx_t short_4by15_size = 8'd7;
localparam cycle_ctx_t short_4by15_tab [`LDPC_HS_MAX_DEPTH] = '{
  '{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd5},
  '{8'd1, 1'b1, 8'd1, 1'b0, 1'b0, 8'd1, 9'd88},
  '{8'd2, 1'b1, 8'd3, 1'b0, 1'b1, 8'd4, 9'd143},
  '{8'd3, 1'b1, 8'd4, 1'b1, 1'b0, 8'd2, 9'd61},
  '{8'd4, 1'b0, 8'd2, 1'b0, 1'b0, 8'd3, 9'd200},
  '{8'd4, 1'b1, 8'd5, 1'b0, 1'b0, 8'd4, 9'd9},
  '{8'd6, 1'b1, 8'd6, 1'b0, 1'b1, 8'd6, 9'd357},
  '0
};

// medium 1/5, two rows of four columns
localparam cycle_idx_t medium_1by5_size = 8'd8;
localparam cycle_ctx_t medium_1by5_tab [`LDPC_HS_MAX_DEPTH] = '{
  '{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd120},
  '{8'd1, 1'b1, 8'd4, 1'b0, 1'b0, 8'd3, 9'd45},
  '{8'd3, 1'b0, 8'd1, 1'b0, 1'b0, 8'd7, 9'd300},
  '{8'd3, 1'b1, 8'd5, 1'b0, 1'b1, 8'd9, 9'd11},
  '{8'd7, 1'b1, 8'd2, 1'b1, 1'b0, 8'd1, 9'd77},
  '{8'd8, 1'b1, 8'd6, 1'b0, 1'b0, 8'd3, 9'd402},
  '{8'd9, 1'b0, 8'd3, 1'b0, 1'b0, 8'd8, 9'd19},
  '{8'd9, 1'b1, 8'd7, 1'b0, 1'b1, 8'd9, 9'd256}
};

// large 2/9, also used for any unlisted group/rate
localparam cycle_idx_t large_2by9_size = 8'd8;
localparam cycle_ctx_t large_2by9_tab [`LDPC_HS_MAX_DEPTH] = '{
  '{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd3},
  '{8'd1, 1'b1, 8'd3, 1'b0, 1'b0, 8'd2, 9'd180},
  '{8'd2, 1'b0, 8'd1, 1'b0, 1'b1, 8'd4, 9'd95},
  '{8'd2, 1'b1, 8'd4, 1'b1, 1'b0, 8'd1, 9'd411},
  '{8'd3, 1'b1, 8'd6, 1'b0, 1'b0, 8'd2, 9'd66},
  '{8'd4, 1'b1, 8'd2, 1'b0, 1'b1, 8'd5, 9'd230},
  '{8'd5, 1'b0, 8'd5, 1'b1, 1'b0, 8'd3, 9'd14},
  '{8'd5, 1'b1, 8'd7, 1'b0, 1'b1, 8'd5, 9'd499}
};

`endif

// ==== hw/ldpc_hs_pkg.sv ====
/*
  LDPC Hs cycle context reader types
  code context, frame strobes, packed table word
  and the check/variable node contexts
*/

`include "ldpc_hs_consts.svh"

package ldpc_hs_pkg;

  // ----------------------------------------
  // scalar fields
  // ----------------------------------------

  typedef logic [`LDPC_HS_COL_W-1:0]   col_t;
  typedef logic [`LDPC_HS_CYCLE_W-1:0] cycle_idx_t;
  typedef logic [`LDPC_HS_SHIFT_W-1:0] shift_t;

  // ----------------------------------------
  // code selection
  // ----------------------------------------

  typedef enum logic [1:0] {
    code_gr_short,
    code_gr_medium,
    code_gr_large
  } code_gr_t;

  // only the kept rates, group is implied by the name
  typedef enum logic [2:0] {
    rate_s_11by45,
    rate_s_4by15,
    rate_m_1by5,
    rate_l_2by9
  } code_rate_t;

  typedef struct packed {
    code_gr_t   gr;
    code_rate_t coderate;
  } code_ctx_t;

  // ----------------------------------------
  // strobes and contexts
  // ----------------------------------------

  typedef struct packed {
    logic sof;
    logic eof;
    logic sop;
    logic eop;
  } strb_t;

  typedef struct packed {
    // vertical step, column ordered
    col_t       vcol_idx;
    logic       veop;
    cycle_idx_t vpacked_addr;
    // horizontal step, row ordered
    logic       mask_0_bit;
    logic       eop;
    col_t       col_idx;
    shift_t     shift;
  } cycle_ctx_t;

  typedef struct packed {
    logic   mask_0_bit;
    shift_t shift;
  } cnode_ctx_t;

  typedef struct packed {
    col_t       col_idx;
    cycle_idx_t paddr;
  } vnode_ctx_t;

endpackage

// ==== hw/ldpc_hs_delay_line.sv ====
/*
  generic delay line
  register chain of pDEPTH stages for any payload type,
  straight through when pDEPTH is zero
*/

`timescale 1ns/1ps

module ldpc_hs_delay_line #(
  parameter type payload_t = logic,
  parameter int  pDEPTH    = 1
) (
  input  logic     iclk,
  input  payload_t din,
  output payload_t dout
);

  generate
    if (pDEPTH == 0) begin : g_bypass
      // no stages
      assign dout = din;
    end
    else begin : g_chain
      payload_t stage [pDEPTH];

      always_ff @(posedge iclk) begin
        stage[0] <= din;
        for (int i = 1; i < pDEPTH; i++) begin
          stage[i] <= stage[i-1];
        end
      end

      // last stage out
      assign dout = stage[pDEPTH-1];
    end
  endgenerate

endmodule

// ==== hw/ldpc_hs_table_rom.sv ====
/*
  LDPC Hs cycle context table rom
  decodes group/rate into one of the packed tables, registers
  the addressed word with its strobe and read flag, and
  reports the table size (large 2/9 for unlisted codes)
*/

`timescale 1ns/1ps

`include "ldpc_hs_consts.svh"

module ldpc_hs_table_rom (
  input  logic                    iclk,
  input  logic                    ireset,
  input  ldpc_hs_pkg::code_ctx_t  code_ctx,
  input  logic                    cycle_read,
  input  ldpc_hs_pkg::strb_t      cycle_strb,
  input  ldpc_hs_pkg::cycle_idx_t cycle_idx,
  output logic                    rom_read,
  output ldpc_hs_pkg::strb_t      rom_strb,
  output ldpc_hs_pkg::cycle_ctx_t rom_word,
  output ldpc_hs_pkg::cycle_idx_t cycle_max_num
);

  import ldpc_hs_pkg::*;

  `include "ldpc_hs_tables.svh"

  localparam int addr_w = $clog2(`LDPC_HS_MAX_DEPTH);

  typedef enum logic [1:0] {
    tab_s_11by45,
    tab_s_4by15,
    tab_m_1by5,
    tab_l_2by9
  } tab_sel_t;

  tab_sel_t            tab_sel;
  logic [addr_w-1:0]   rom_addr;

  // ----------------------------------------
  // table decode
  // ----------------------------------------

  always_comb begin
    // default table
    tab_sel = tab_l_2by9;
    case (code_ctx.gr)
      code_gr_short : begin
        case (code_ctx.coderate)
          rate_s_11by45 : tab_sel = tab_s_11by45;
          rate_s_4by15  : tab_sel = tab_s_4by15;
          default       : tab_sel = tab_l_2by9;
        endcase
      end
      code_gr_medium : begin
        if (code_ctx.coderate == rate_m_1by5) begin
          tab_sel = tab_m_1by5;
        end
      end
      default : tab_sel = tab_l_2by9;
    endcase
  end

  // cycle count straight from the decode
  always_comb begin
    case (tab_sel)
      tab_s_11by45 : cycle_max_num = short_11by45_size;
      tab_s_4by15  : cycle_max_num = short_4by15_size;
      tab_m_1by5   : cycle_max_num = medium_1by5_size;
      default      : cycle_max_num = large_2by9_size;
    endcase
  end

  // ----------------------------------------
  // registered read
  // ----------------------------------------

  // tables never exceed max depth
  assign rom_addr = cycle_idx[addr_w-1:0];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rom_read <= 1'b0;
    end
    else begin
      rom_read <= cycle_read;
    end
  end

  always_ff @(posedge iclk) begin
    rom_strb <= cycle_strb;
    case (tab_sel)
      tab_s_11by45 : rom_word <= short_11by45_tab[rom_addr];
      tab_s_4by15  : rom_word <= short_4by15_tab[rom_addr];
      tab_m_1by5   : rom_word <= medium_1by5_tab[rom_addr];
      default      : rom_word <= large_2by9_tab[rom_addr];
    endcase
  end

endmodule

// ==== hw/ldpc_hs_addr_gen.sv ====
/*
  LDPC Hs read address generator
  turns delayed table words into llr and node memory read
  addresses for the horizontal or vertical step, and builds
  the check/variable node strobes with sop regeneration
*/

`timescale 1ns/1ps

module ldpc_hs_addr_gen #(
  parameter int pPIPE = 1
) (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    cycle_start,
  input  logic                    c_nv_mode,
  input  logic                    rom_read,
  input  ldpc_hs_pkg::cycle_ctx_t ctx_word,
  input  ldpc_hs_pkg::strb_t      ctx_strb,
  output logic                    cycle_read_out,
  output ldpc_hs_pkg::col_t       llr_raddr,
  output ldpc_hs_pkg::cycle_idx_t node_raddr,
  output ldpc_hs_pkg::strb_t      cnode_strb,
  output ldpc_hs_pkg::cnode_ctx_t cnode_ctx,
  output ldpc_hs_pkg::strb_t      vnode_strb,
  output ldpc_hs_pkg::vnode_ctx_t vnode_ctx
);

  import ldpc_hs_pkg::*;

  // ----------------------------------------
  // read flag alignment
  // ----------------------------------------

  // bit 0 is the rom flag, bit pPIPE lines up with ctx_word
  logic [pPIPE:0] read_sr;
  logic           used_read;

  assign read_sr[0] = rom_read;

  generate
    for (genvar i = 1; i <= pPIPE; i++) begin : g_read_sr
      always_ff @(posedge iclk or posedge ireset) begin
        if (ireset) begin
          read_sr[i] <= 1'b0;
        end
        else begin
          read_sr[i] <= read_sr[i-1];
        end
      end
    end
  endgenerate

  assign used_read = read_sr[pPIPE];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cycle_read_out <= 1'b0;
    end
    else begin
      cycle_read_out <= used_read;
    end
  end

  // ----------------------------------------
  // addresses and node contexts
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (cycle_start) begin
      llr_raddr  <= '0;
      // first horizontal read lands on 0
      node_raddr <= '1;
    end
    else if (used_read) begin
      if (c_nv_mode) begin
        // horizontal step, node memory is linear
        llr_raddr  <= ctx_word.col_idx;
        node_raddr <= node_raddr + 1'b1;
      end
      else begin
        llr_raddr  <= ctx_word.vcol_idx;
        node_raddr <= ctx_word.vpacked_addr;
      end
    end
    // cnode side
    cnode_strb.sof       <= ctx_strb.sof;
    cnode_strb.eof       <= ctx_strb.eof;
    cnode_strb.eop       <= ctx_word.eop;
    cnode_ctx.mask_0_bit <= ctx_word.mask_0_bit;
    cnode_ctx.shift      <= ctx_word.shift;
    // sop after start or after the previous eop
    if (cycle_start | cnode_strb.eop) begin
      cnode_strb.sop <= 1'b1;
    end
    else if (cycle_read_out) begin
      cnode_strb.sop <= 1'b0;
    end
    // vnode side
    vnode_strb.sof <= ctx_strb.sof;
    vnode_strb.eof <= ctx_strb.eof;
    vnode_strb.eop <= ctx_word.veop;
    if (cycle_start | vnode_strb.eop) begin
      vnode_strb.sop <= 1'b1;
    end
    else if (cycle_read_out) begin
      vnode_strb.sop <= 1'b0;
    end
  end

  // vnode context follows the address registers
  assign vnode_ctx.col_idx = llr_raddr;
  assign vnode_ctx.paddr   = node_raddr;

endmodule

// ==== hw/ldpc_hs_ctx_reader.sv ====
/*
  LDPC Hs cycle context reader, top level
  table rom, word/strobe delay lines and the address generator
  read to outputs latency is 2 + pPIPE cycles
*/

`timescale 1ns/1ps

`include "ldpc_hs_consts.svh"

module ldpc_hs_ctx_reader #(
  parameter int pPIPE = `LDPC_HS_PIPE
) (
  input  logic                    iclk,
  input  logic                    ireset,
  input  ldpc_hs_pkg::code_ctx_t  code_ctx,
  input  logic                    cycle_start,
  input  logic                    c_nv_mode,
  input  logic                    cycle_read,
  input  ldpc_hs_pkg::strb_t      cycle_strb,
  input  ldpc_hs_pkg::cycle_idx_t cycle_idx,
  output ldpc_hs_pkg::cycle_idx_t cycle_max_num,
  output logic                    cycle_read_out,
  output ldpc_hs_pkg::col_t       llr_raddr,
  output ldpc_hs_pkg::cycle_idx_t node_raddr,
  output ldpc_hs_pkg::strb_t      cnode_strb,
  output ldpc_hs_pkg::cnode_ctx_t cnode_ctx,
  output ldpc_hs_pkg::strb_t      vnode_strb,
  output ldpc_hs_pkg::vnode_ctx_t vnode_ctx
);

  import ldpc_hs_pkg::*;

  logic       rom_read;
  strb_t      rom_strb;
  strb_t      dly_strb;
  cycle_ctx_t rom_word;
  cycle_ctx_t dly_word;

  // ----------------------------------------
  // table read, 1 cycle
  // ----------------------------------------

  ldpc_hs_table_rom table_rom_i (
    .iclk          (iclk),
    .ireset        (ireset),
    .code_ctx      (code_ctx),
    .cycle_read    (cycle_read),
    .cycle_strb    (cycle_strb),
    .cycle_idx     (cycle_idx),
    .rom_read      (rom_read),
    .rom_strb      (rom_strb),
    .rom_word      (rom_word),
    .cycle_max_num (cycle_max_num)
  );

  // word and strobe pipeline, read flag is delayed in addr gen
  ldpc_hs_delay_line #(
    .payload_t (cycle_ctx_t),
    .pDEPTH    (pPIPE)
  ) word_delay_i (
    .iclk (iclk),
    .din  (rom_word),
    .dout (dly_word)
  );

  ldpc_hs_delay_line #(
    .payload_t (strb_t),
    .pDEPTH    (pPIPE)
  ) strb_delay_i (
    .iclk (iclk),
    .din  (rom_strb),
    .dout (dly_strb)
  );

  // ----------------------------------------
  // address generation, 1 cycle
  // ----------------------------------------

  ldpc_hs_addr_gen #(
    .pPIPE (pPIPE)
  ) addr_gen_i (
    .iclk           (iclk),
    .ireset         (ireset),
    .cycle_start    (cycle_start),
    .c_nv_mode      (c_nv_mode),
    .rom_read       (rom_read),
    .ctx_word       (dly_word),
    .ctx_strb       (dly_strb),
    .cycle_read_out (cycle_read_out),
    .llr_raddr      (llr_raddr),
    .node_raddr     (node_raddr),
    .cnode_strb     (cnode_strb),
    .cnode_ctx      (cnode_ctx),
    .vnode_strb     (vnode_strb),
    .vnode_ctx      (vnode_ctx)
  );

endmodule

// ==== bench/ldpc_hs_ctx_reader_checker.sv ====
/*
  LDPC Hs cycle context reader assertions
  reset state, fixed read to output latency
  and the address values after a start
*/

`timescale 1ns/1ps

module ldpc_hs_ctx_reader_checker #(
  parameter int pPIPE = 1
) (
  input logic                    iclk,
  input logic                    ireset,
  input logic                    cycle_start,
  input logic                    cycle_read,
  input logic                    cycle_read_out,
  input ldpc_hs_pkg::col_t       llr_raddr,
  input ldpc_hs_pkg::cycle_idx_t node_raddr
);

  // rom stage, delay line, output register
  localparam int lat = pPIPE + 2;

  // no output read while reset is held
  a_reset_idle : assert property (@(posedge iclk) ireset |-> !cycle_read_out)
    else $error("cycle_read_out high during reset");

  a_read_latency : assert property (@(posedge iclk) disable iff (ireset)
    cycle_read |-> ##lat cycle_read_out)
    else $error("read did not reach cycle_read_out in %0d cycles", lat);

  // every output read has a matching input read
  a_no_spurious : assert property (@(posedge iclk) disable iff (ireset)
    cycle_read_out |-> $past(cycle_read, lat))
    else $error("cycle_read_out without an earlier read");

  a_start_addr : assert property (@(posedge iclk) disable iff (ireset)
    cycle_start |=> (llr_raddr == '0) && (node_raddr == '1))
    else $error("addresses not cleared after cycle_start");

endmodule

bind ldpc_hs_ctx_reader ldpc_hs_ctx_reader_checker #(
  .pPIPE (pPIPE)
) checker_i (
  .iclk           (iclk),
  .ireset         (ireset),
  .cycle_start    (cycle_start),
  .cycle_read     (cycle_read),
  .cycle_read_out (cycle_read_out),
  .llr_raddr      (llr_raddr),
  .node_raddr     (node_raddr)
);

// ==== bench/ldpc_hs_ctx_reader_tb.sv ====
/*
  testbench for the LDPC Hs cycle context reader
  table driven passes over the four code tables in both steps,
  checks cycle count, addresses, node contexts and strobes
*/

`timescale 1ns/1ps

`include "ldpc_hs_consts.svh"

module ldpc_hs_ctx_reader_tb;

  import ldpc_hs_pkg::*;

  // ----------------------------------------
  // stimulus and reference tables
  // ----------------------------------------

  // one pass reads n_reads words upward from first_idx
  typedef struct packed {
    code_ctx_t  ctx;
    logic       mode;
    logic [7:0] first_idx;
    logic [7:0] n_reads;
    logic [1:0] tab;
    logic       burst;
  } pass_t;

  // expected outputs for one read
  typedef struct packed {
    int         due;
    col_t       llr;
    cycle_idx_t node;
    cycle_ctx_t w;
    logic       csop;
    logic       vsop;
    logic       sof;
    logic       eof;
  } exp_t;

  // tab 3 is also the expected table for unlisted codes
  localparam pass_t passes [8] = '{
    '{'{code_gr_short, rate_s_11by45}, 1'b1, 8'd0, 8'd6, 2'd0, 1'b1},
    '{'{code_gr_short, rate_s_4by15}, 1'b0, 8'd0, 8'd7, 2'd1, 1'b0},
    '{'{code_gr_medium, rate_m_1by5}, 1'b1, 8'd0, 8'd8, 2'd2, 1'b0},
    '{'{code_gr_large, rate_l_2by9}, 1'b0, 8'd0, 8'd8, 2'd3, 1'b1},
    '{'{code_gr_medium, rate_s_4by15}, 1'b1, 8'd2, 8'd5, 2'd3, 1'b0},
    '{'{code_gr_large, rate_s_11by45}, 1'b0, 8'd0, 8'd8, 2'd3, 1'b1},
    '{'{code_gr_short, rate_s_11by45}, 1'b0, 8'd0, 8'd6, 2'd0, 1'b0},
    '{'{code_gr_large, rate_l_2by9}, 1'b1, 8'd0, 8'd8, 2'd3, 1'b1}
  };

  localparam cycle_idx_t ref_size [4] = '{8'd6, 8'd7, 8'd8, 8'd8};

  // vcol_idx, veop, vpacked_addr, mask_0_bit, eop, col_idx, shift
  localparam cycle_ctx_t ref_tab [4][`LDPC_HS_MAX_DEPTH] = '{
    '{'{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd17},
      '{8'd1, 1'b1, 8'd3, 1'b0, 1'b0, 8'd2, 9'd101},
      '{8'd2, 1'b1, 8'd1, 1'b0, 1'b1, 8'd5, 9'd250},
      '{8'd3, 1'b1, 8'd4, 1'b1, 1'b0, 8'd1, 9'd33},
      '{8'd5, 1'b0, 8'd2, 1'b0, 1'b0, 8'd3, 9'd7},
      '{8'd5, 1'b1, 8'd5, 1'b0, 1'b1, 8'd5, 9'd310},
      '0,
      '0},
    '{'{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd5},
      '{8'd1, 1'b1, 8'd1, 1'b0, 1'b0, 8'd1, 9'd88},
      '{8'd2, 1'b1, 8'd3, 1'b0, 1'b1, 8'd4, 9'd143},
      '{8'd3, 1'b1, 8'd4, 1'b1, 1'b0, 8'd2, 9'd61},
      '{8'd4, 1'b0, 8'd2, 1'b0, 1'b0, 8'd3, 9'd200},
      '{8'd4, 1'b1, 8'd5, 1'b0, 1'b0, 8'd4, 9'd9},
      '{8'd6, 1'b1, 8'd6, 1'b0, 1'b1, 8'd6, 9'd357},
      '0},
    '{'{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd120},
      '{8'd1, 1'b1, 8'd4, 1'b0, 1'b0, 8'd3, 9'd45},
      '{8'd3, 1'b0, 8'd1, 1'b0, 1'b0, 8'd7, 9'd300},
      '{8'd3, 1'b1, 8'd5, 1'b0, 1'b1, 8'd9, 9'd11},
      '{8'd7, 1'b1, 8'd2, 1'b1, 1'b0, 8'd1, 9'd77},
      '{8'd8, 1'b1, 8'd6, 1'b0, 1'b0, 8'd3, 9'd402},
      '{8'd9, 1'b0, 8'd3, 1'b0, 1'b0, 8'd8, 9'd19},
      '{8'd9, 1'b1, 8'd7, 1'b0, 1'b1, 8'd9, 9'd256}},
    '{'{8'd0, 1'b1, 8'd0, 1'b1, 1'b0, 8'd0, 9'd3},
      '{8'd1, 1'b1, 8'd3, 1'b0, 1'b0, 8'd2, 9'd180},
      '{8'd2, 1'b0, 8'd1, 1'b0, 1'b1, 8'd4, 9'd95},
      '{8'd2, 1'b1, 8'd4, 1'b1, 1'b0, 8'd1, 9'd411},
      '{8'd3, 1'b1, 8'd6, 1'b0, 1'b0, 8'd2, 9'd66},
      '{8'd4, 1'b1, 8'd2, 1'b0, 1'b1, 8'd5, 9'd230},
      '{8'd5, 1'b0, 8'd5, 1'b1, 1'b0, 8'd3, 9'd14},
      '{8'd5, 1'b1, 8'd7, 1'b0, 1'b1, 8'd5, 9'd499}}
  };

  // ----------------------------------------
  // DUT and clock
  // ----------------------------------------

  logic       iclk;
  logic       ireset;
  code_ctx_t  code_ctx;
  logic       cycle_start;
  logic       c_nv_mode;
  logic       cycle_read;
  strb_t      cycle_strb;
  cycle_idx_t cycle_idx;
  cycle_idx_t cycle_max_num;
  logic       cycle_read_out;
  col_t       llr_raddr;
  cycle_idx_t node_raddr;
  strb_t      cnode_strb;
  cnode_ctx_t cnode_ctx;
  strb_t      vnode_strb;
  vnode_ctx_t vnode_ctx;

  int         errors;
  int         n_checked;
  int         cyc;
  int         seed;
  logic       aborted;
  exp_t       exp_q [$];

  ldpc_hs_ctx_reader #(
    .pPIPE (1)
  ) ldpc_hs_ctx_reader_i (
    .iclk           (iclk),
    .ireset         (ireset),
    .code_ctx       (code_ctx),
    .cycle_start    (cycle_start),
    .c_nv_mode      (c_nv_mode),
    .cycle_read     (cycle_read),
    .cycle_strb     (cycle_strb),
    .cycle_idx      (cycle_idx),
    .cycle_max_num  (cycle_max_num),
    .cycle_read_out (cycle_read_out),
    .llr_raddr      (llr_raddr),
    .node_raddr     (node_raddr),
    .cnode_strb     (cnode_strb),
    .cnode_ctx      (cnode_ctx),
    .vnode_strb     (vnode_strb),
    .vnode_ctx      (vnode_ctx)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got %h expected %h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  // one clock, outputs sampled 1 ns after the edge, then new inputs may go
  task automatic next_cycle();
    exp_t       e;
    cnode_ctx_t ec;
    vnode_ctx_t ev;
    strb_t      ecs;
    strb_t      evs;
    @(posedge iclk);
    #1;
    cyc++;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e   = exp_q.pop_front();
      ec  = '{e.w.mask_0_bit, e.w.shift};
      ev  = '{e.llr, e.node};
      ecs = '{e.sof, e.eof, e.csop, e.w.eop};
      evs = '{e.sof, e.eof, e.vsop, e.w.veop};
      n_checked++;
      check_value("cycle_read_out", 16'(cycle_read_out), 16'h1);
      check_value("llr_raddr", 16'(llr_raddr), 16'(e.llr));
      check_value("node_raddr", 16'(node_raddr), 16'(e.node));
      check_value("cnode_ctx", 16'(cnode_ctx), 16'(ec));
      check_value("vnode_ctx", 16'(vnode_ctx), 16'(ev));
      check_value("cnode_strb", 16'(cnode_strb), 16'(ecs));
      check_value("vnode_strb", 16'(vnode_strb), 16'(evs));
    end
    else begin
      // nothing due, no output read either
      check_value("cycle_read_out", 16'(cycle_read_out), 16'h0);
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 10) begin
      next_cycle();
      t++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: %0d reads never came out of the DUT", exp_q.size());
    end
  endtask

  task automatic run_pass(input pass_t ps);
    cycle_ctx_t w;
    cycle_ctx_t prev;
    exp_t       e;
    int         gap;
    wait_drain();
    if (aborted) begin
      return;
    end
    next_cycle();
    code_ctx    = ps.ctx;
    c_nv_mode   = ps.mode;
    cycle_start = 1'b1;
    next_cycle();
    cycle_start = 1'b0;
    // size is combinational, start values one edge after start
    check_value("cycle_max_num", 16'(cycle_max_num), 16'(ref_size[ps.tab]));
    check_value("llr_raddr", 16'(llr_raddr), 16'h0);
    check_value("node_raddr", 16'(node_raddr), 16'hff);
    prev = '0;
    for (int k = 0; k < int'(ps.n_reads); k++) begin
      w      = ref_tab[ps.tab][int'(ps.first_idx) + k];
      e.due  = cyc + 3;
      e.w    = w;
      e.llr  = ps.mode ? w.col_idx : w.vcol_idx;
      e.node = ps.mode ? cycle_idx_t'(k) : w.vpacked_addr;
      // sop on the first word and after every eop
      e.csop = (k == 0) || prev.eop;
      e.vsop = (k == 0) || prev.veop;
      e.sof  = (k == 0);
      e.eof  = (k == int'(ps.n_reads) - 1);
      exp_q.push_back(e);
      cycle_read = 1'b1;
      cycle_idx  = ps.first_idx + 8'(k);
      cycle_strb = '{e.sof, e.eof, 1'b0, 1'b0};
      next_cycle();
      // index held through idle cycles
      cycle_read = 1'b0;
      cycle_strb = '0;
      if (!ps.burst) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) next_cycle();
      end
      prev = w;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    errors      = 0;
    n_checked   = 0;
    cyc         = 0;
    seed        = 63;
    aborted     = 1'b0;
    ireset      = 1'b1;
    code_ctx    = '{code_gr_short, rate_s_11by45};
    cycle_start = 1'b0;
    c_nv_mode   = 1'b0;
    cycle_read  = 1'b0;
    cycle_strb  = '0;
    cycle_idx   = '0;
    repeat (4) @(posedge iclk);
    #1;
    check_value("cycle_read_out", 16'(cycle_read_out), 16'h0);
    ireset = 1'b0;
    for (int p = 0; p < 8; p++) begin
      if (!aborted) begin
        run_pass(passes[p]);
      end
    end
    wait_drain();
    $display("errors: %0d, reads checked: %0d", errors, n_checked);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end
    else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
hw/ldpc_hs_pkg.sv
hw/ldpc_hs_delay_line.sv
hw/ldpc_hs_table_rom.sv
hw/ldpc_hs_addr_gen.sv
hw/ldpc_hs_ctx_reader.sv
bench/ldpc_hs_ctx_reader_checker.sv
bench/ldpc_hs_ctx_reader_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the LDPC Hs cycle context reader

VERILATOR ?= verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = ldpc_hs_ctx_reader_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = STATUS: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
